//--- hdl/uart_pkg.sv
package uart_pkg;

	// frame format defaults
	localparam int unsigned DEF_DATA_WIDTH = 8; // data bits per frame
	localparam bit DEF_PARITY_ENABLE = 1'b1; // send and check a parity bit
	localparam bit DEF_PARITY_ODD = 1'b0; // 0 even, 1 odd

	// timing defaults, one bit = CLKS_PER_SAMPLE * SAMPLES_PER_BIT clocks
	localparam int unsigned DEF_CLKS_PER_SAMPLE = 2; // tx_clk cycles per oversampling tick
	localparam int unsigned DEF_SAMPLES_PER_BIT = 8; // oversampling ticks per line bit

	// receiver input synchronizer depth
	localparam int unsigned DEF_SYNC_STAGES = 3;

	// transmitter FSM
	typedef enum logic [2:0] {
		TX_IDLE      = 3'd0, // line high, waiting for a request
		TX_WAIT_TICK = 3'd1, // request latched, waiting for a bit boundary
		TX_SHIFT     = 3'd2, // start, data and parity bits on the line
		TX_STOP      = 3'd3  // stop bit on the line
	} tx_state_t;

	// receiver FSM
	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0, // waiting for a falling edge
		RX_START  = 3'd1, // counting to the middle of the start bit
		RX_DATA   = 3'd2, // sampling data bits, lsb first
		RX_PARITY = 3'd3, // sampling the parity bit
		RX_STOP   = 3'd4  // sampling the stop bit
	} rx_state_t;

endpackage

//--- hdl/uart_tick_gen.sv
module uart_tick_gen
	import uart_pkg::*;
#(
	parameter int unsigned CLKS_PER_SAMPLE = DEF_CLKS_PER_SAMPLE,
	parameter int unsigned SAMPLES_PER_BIT = DEF_SAMPLES_PER_BIT
) (
	input  logic tx_clk,
	input  logic reset_tx,
	output logic o_sample_tick, // one cycle every CLKS_PER_SAMPLE clocks
	output logic o_bit_tick     // one cycle every SAMPLES_PER_BIT sample ticks
);

	localparam int CW = (CLKS_PER_SAMPLE > 1) ? $clog2(CLKS_PER_SAMPLE) : 1;
	localparam int SW = (SAMPLES_PER_BIT > 1) ? $clog2(SAMPLES_PER_BIT) : 1;

	logic [CW-1:0] clk_cnt; // clocks within one sample period
	logic [SW-1:0] smp_cnt; // sample ticks within one bit period

	// both strobes come out of flops, so they are glitch free clock enables
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			clk_cnt       <= '0;
			smp_cnt       <= '0;
			o_sample_tick <= 1'b0;
			o_bit_tick    <= 1'b0;
		end else begin
			o_sample_tick <= 1'b0; // default low, pulses for one cycle
			o_bit_tick    <= 1'b0;
			if (clk_cnt == CW'(CLKS_PER_SAMPLE - 1)) begin
				clk_cnt       <= '0; // wrap and fire the sample strobe
				o_sample_tick <= 1'b1;
				if (smp_cnt == SW'(SAMPLES_PER_BIT - 1)) begin
					smp_cnt    <= '0; // last sample of the bit marks the boundary
					o_bit_tick <= 1'b1;
				end else begin
					smp_cnt <= smp_cnt + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

//--- hdl/uart_tx.sv
module uart_tx
	import uart_pkg::*;
#(
	parameter int unsigned DATA_WIDTH    = DEF_DATA_WIDTH,
	parameter bit          PARITY_ENABLE = DEF_PARITY_ENABLE,
	parameter bit          PARITY_ODD    = DEF_PARITY_ODD
) (
	input  logic                  tx_clk,
	input  logic                  reset_tx,
	input  logic                  i_bit_tick, // bit boundary strobe from the tick generator
	input  logic                  i_tx_start, // one cycle request, ignored while busy
	input  logic [DATA_WIDTH-1:0] i_tx_data,  // captured with an accepted request
	output logic                  o_serial,   // idles high
	output logic                  o_tx_busy
);

	// start + data + optional parity + stop
	localparam int FW = DATA_WIDTH + int'(PARITY_ENABLE) + 2;
	localparam int BW = $clog2(FW);

	tx_state_t     state_q;
	logic [BW-1:0] bit_cnt;    // index of the bit currently on the line
	logic [FW-1:0] frame_q;    // outgoing frame, bit 0 goes out next
	logic [FW-1:0] frame_load; // frame built from the request data
	logic          par_bit;    // parity of the request data
	logic          tx_accept;  // request taken this cycle
	logic          shift_en;   // next frame bit moves to the line

	assign par_bit = (^i_tx_data) ^ PARITY_ODD; // odd parity inverts the xor

	generate
		if (PARITY_ENABLE) begin : g_par
			assign frame_load = {1'b1, par_bit, i_tx_data, 1'b0}; // stop, parity, data, start
		end else begin : g_nopar
			assign frame_load = {1'b1, i_tx_data, 1'b0}; // parity bit not sent
		end
	endgenerate

	assign tx_accept = (state_q == TX_IDLE) && i_tx_start;
	assign shift_en  = i_bit_tick && ((state_q == TX_WAIT_TICK) || (state_q == TX_SHIFT));
	assign o_tx_busy = (state_q != TX_IDLE); // high from the cycle after the request

	// frame register, loaded on request and shifted on bit ticks
	always_ff @(posedge tx_clk) begin
		if (tx_accept) begin
			frame_q <= frame_load;
		end else if (shift_en) begin
			frame_q <= {1'b1, frame_q[FW-1:1]}; // fill with ones behind the frame
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q  <= TX_IDLE;
			bit_cnt  <= '0;
			o_serial <= 1'b1; // line idles high
		end else begin
			case (state_q)
				TX_IDLE: begin
					o_serial <= 1'b1;
					if (i_tx_start) begin
						state_q <= TX_WAIT_TICK; // wait for the next bit boundary
					end
				end
				TX_WAIT_TICK: begin
					if (i_bit_tick) begin
						o_serial <= frame_q[0]; // start bit
						bit_cnt  <= BW'(1);
						state_q  <= TX_SHIFT;
					end
				end
				TX_SHIFT: begin
					if (i_bit_tick) begin
						o_serial <= frame_q[0];
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == BW'(FW - 1)) begin
							state_q <= TX_STOP; // stop bit now on the line
						end
					end
				end
				TX_STOP: begin
					if (i_bit_tick) begin
						state_q <= TX_IDLE; // stop bit period is over, busy drops
						bit_cnt <= '0;
					end
				end
				default: begin
					state_q  <= TX_IDLE;
					o_serial <= 1'b1;
				end
			endcase
		end
	end

endmodule

//--- hdl/uart_rx.sv
module uart_rx
	import uart_pkg::*;
#(
	parameter int unsigned DATA_WIDTH      = DEF_DATA_WIDTH,
	parameter bit          PARITY_ENABLE   = DEF_PARITY_ENABLE,
	parameter bit          PARITY_ODD      = DEF_PARITY_ODD,
	parameter int unsigned SAMPLES_PER_BIT = DEF_SAMPLES_PER_BIT,
	parameter int unsigned SYNC_STAGES     = DEF_SYNC_STAGES
) (
	input  logic                  tx_clk,
	input  logic                  reset_tx,
	input  logic                  i_sample_tick, // oversampling strobe
	input  logic                  i_serial,      // asynchronous line input
	output logic [DATA_WIDTH-1:0] o_rx_data,     // held until the next valid pulse
	output logic                  o_rx_valid,    // one cycle per received frame
	output logic                  o_rx_error     // parity or stop bit error, with valid
);

	localparam int TW   = (SAMPLES_PER_BIT > 1) ? $clog2(SAMPLES_PER_BIT) : 1;
	localparam int BW   = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
	localparam int HALF = (SAMPLES_PER_BIT > 1) ? (SAMPLES_PER_BIT / 2) : 1;

	logic [SYNC_STAGES-1:0] sync_q;  // new sample enters at bit 0
	logic                   rx_line; // synchronized line
	logic                   rx_prev; // line one cycle earlier, for edge detection
	rx_state_t              state_q;
	logic [TW-1:0]          tick_cnt; // sample ticks within the current bit
	logic [BW-1:0]          bit_idx;  // data bit being sampled
	logic                   par_acc;  // running parity, seeded for odd parity
	logic                   par_err;
	logic                   bit_done;    // middle of a data, parity or stop bit
	logic                   data_sample; // a data bit is taken this cycle
	logic                   stop_sample; // the stop bit is taken this cycle
	logic [DATA_WIDTH-1:0]  shift_q;     // deframed data, lsb arrives first

	assign rx_line     = sync_q[SYNC_STAGES-1];
	assign bit_done    = i_sample_tick && (tick_cnt == TW'(SAMPLES_PER_BIT - 1));
	assign data_sample = bit_done && (state_q == RX_DATA);
	assign stop_sample = bit_done && (state_q == RX_STOP);

	// data path, shifts right so the first bit ends up in bit 0
	always_ff @(posedge tx_clk) begin
		if (data_sample) begin
			shift_q <= DATA_WIDTH'({rx_line, shift_q} >> 1);
		end
		if (stop_sample) begin
			o_rx_data <= shift_q;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q     <= '1; // pretend idle line so reset does not look like a start
			rx_prev    <= 1'b1;
			state_q    <= RX_IDLE;
			tick_cnt   <= '0;
			bit_idx    <= '0;
			par_acc    <= 1'b0;
			par_err    <= 1'b0;
			o_rx_valid <= 1'b0;
			o_rx_error <= 1'b0;
		end else begin
			sync_q     <= SYNC_STAGES'({sync_q, i_serial});
			rx_prev    <= rx_line;
			o_rx_valid <= 1'b0;

			// bit phase counter, restarted at mid start so later samples land mid bit
			if (i_sample_tick && (state_q inside {RX_DATA, RX_PARITY, RX_STOP})) begin
				tick_cnt <= bit_done ? '0 : tick_cnt + 1'b1;
			end

			case (state_q)
				RX_IDLE: begin
					if (rx_prev && !rx_line) begin
						state_q  <= RX_START; // falling edge, possible start bit
						tick_cnt <= '0;
					end
				end
				RX_START: begin
					if (i_sample_tick) begin
						if (tick_cnt == TW'(HALF - 1)) begin
							tick_cnt <= '0;
							if (rx_line) begin
								state_q <= RX_IDLE; // line back high, only a glitch
							end else begin
								state_q <= RX_DATA;
								bit_idx <= '0;
								par_acc <= PARITY_ODD;
								par_err <= 1'b0;
							end
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				RX_DATA: begin
					if (bit_done) begin
						par_acc <= par_acc ^ rx_line;
						if (bit_idx == BW'(DATA_WIDTH - 1)) begin
							state_q <= PARITY_ENABLE ? RX_PARITY : RX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				RX_PARITY: begin
					if (bit_done) begin
						par_err <= par_acc ^ rx_line; // nonzero means mismatch
						state_q <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (bit_done) begin
						o_rx_valid <= 1'b1;
						o_rx_error <= par_err | ~rx_line; // low stop bit is a framing error
						state_q    <= RX_IDLE;
					end
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/uart_top.sv
module uart_top
	import uart_pkg::*;
#(
	parameter int unsigned DATA_WIDTH      = DEF_DATA_WIDTH,
	parameter bit          PARITY_ENABLE   = DEF_PARITY_ENABLE,
	parameter bit          PARITY_ODD      = DEF_PARITY_ODD,
	parameter int unsigned CLKS_PER_SAMPLE = DEF_CLKS_PER_SAMPLE,
	parameter int unsigned SAMPLES_PER_BIT = DEF_SAMPLES_PER_BIT,
	parameter int unsigned SYNC_STAGES     = DEF_SYNC_STAGES
) (
	input  logic                  tx_clk,
	input  logic                  reset_tx,
	input  logic                  i_tx_start,
	input  logic [DATA_WIDTH-1:0] i_tx_data,
	input  logic                  i_serial,  // receiver line, looped back outside
	output logic                  o_serial,  // transmitter line
	output logic                  o_tx_busy,
	output logic [DATA_WIDTH-1:0] o_rx_data,
	output logic                  o_rx_valid,
	output logic                  o_rx_error
);

	logic sample_tick; // receiver oversampling strobe
	logic bit_tick;    // transmitter bit strobe

	uart_tick_gen #(
		.CLKS_PER_SAMPLE(CLKS_PER_SAMPLE),
		.SAMPLES_PER_BIT(SAMPLES_PER_BIT)
	) u_tick_gen (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.o_sample_tick(sample_tick),
		.o_bit_tick   (bit_tick)
	);

	uart_tx #(
		.DATA_WIDTH   (DATA_WIDTH),
		.PARITY_ENABLE(PARITY_ENABLE),
		.PARITY_ODD   (PARITY_ODD)
	) u_tx (
		.tx_clk    (tx_clk),
		.reset_tx  (reset_tx),
		.i_bit_tick(bit_tick),
		.i_tx_start(i_tx_start),
		.i_tx_data (i_tx_data),
		.o_serial  (o_serial),
		.o_tx_busy (o_tx_busy)
	);

	// receiver keeps its own bit phase, it only needs the sample strobe
	uart_rx #(
		.DATA_WIDTH     (DATA_WIDTH),
		.PARITY_ENABLE  (PARITY_ENABLE),
		.PARITY_ODD     (PARITY_ODD),
		.SAMPLES_PER_BIT(SAMPLES_PER_BIT),
		.SYNC_STAGES    (SYNC_STAGES)
	) u_rx (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_sample_tick(sample_tick),
		.i_serial     (i_serial),
		.o_rx_data    (o_rx_data),
		.o_rx_valid   (o_rx_valid),
		.o_rx_error   (o_rx_error)
	);

endmodule

//--- test/tb_uart_top.sv
module tb_uart_top
	import uart_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DATA_W        = DEF_DATA_WIDTH;
	localparam int BIT_CLKS      = DEF_CLKS_PER_SAMPLE * DEF_SAMPLES_PER_BIT; // 16 clocks per bit
	localparam int FRAME_BITS    = DATA_W + 3; // start, data, parity, stop
	localparam int CLK_NS        = 20;
	localparam int RESET_CYCLES  = 4;
	localparam int LOOP_WORDS    = 16;
	localparam int FRAMES_IN_RUN = 23; // 21 frames plus the two frame idle of the false start
	localparam longint WATCHDOG_NS = 2 * FRAMES_IN_RUN * FRAME_BITS * BIT_CLKS * CLK_NS;

	logic              tx_clk;
	logic              reset_tx;
	logic              tx_start;
	logic [DATA_W-1:0] tx_data;
	logic              serial_out; // transmitter line
	logic              serial_in;  // receiver line
	logic              busy;
	logic [DATA_W-1:0] rx_data;
	logic              rx_valid;
	logic              rx_error;
	logic              loopback;   // 1 closes the line, 0 lets the tb drive it
	logic              line_drv;   // tb level on the line when not looped back
	logic [15:0]       lfsr_q;
	int                valid_count; // valid pulses since the last request
	logic [DATA_W-1:0] seen_data;   // o_rx_data at the last valid pulse
	logic              seen_error;

	assign serial_in = loopback ? serial_out : line_drv;

	uart_top DUT (
		.tx_clk    (tx_clk),
		.reset_tx  (reset_tx),
		.i_tx_start(tx_start),
		.i_tx_data (tx_data),
		.i_serial  (serial_in),
		.o_serial  (serial_out),
		.o_tx_busy (busy),
		.o_rx_data (rx_data),
		.o_rx_valid(rx_valid),
		.o_rx_error(rx_error)
	);

	always #(CLK_NS / 2) tx_clk = ~tx_clk;

	// receive monitor, one negedge per valid pulse
	always @(negedge tx_clk) begin
		if (rx_valid === 1'b1) begin
			valid_count = valid_count + 1;
			seen_data   = rx_data;
			seen_error  = rx_error;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure($sformatf("watchdog: run did not finish within %0d ns", WATCHDOG_NS));
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10]; // x^16 + x^14 + x^13 + x^11
		return {s[14:0], fb};
	endfunction

	function automatic logic xor_parity(input logic [DATA_W-1:0] d);
		logic p;
		p = 1'b0;
		for (int i = 0; i < DATA_W; i++) begin
			p = p ^ d[i]; // even parity bit
		end
		return p;
	endfunction

	task automatic draw_data(output logic [DATA_W-1:0] d);
		for (int i = 0; i < DATA_W; i++) begin
			lfsr_q = lfsr_next(lfsr_q); // one step per bit taken
			d[i]   = lfsr_q[0];
		end
	endtask

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic value_error(input string msg);
		report_failure($sformatf("[FAIL] %0d ns: %s", $time, msg));
	endtask

	task automatic next_cycle();
		@(posedge tx_clk);
		#2; // drive point
	endtask

	task automatic expect_idle_outputs(input string where);
		assert (serial_out === 1'b1) else value_error($sformatf("o_serial %b %s", serial_out, where));
		assert (busy === 1'b0) else value_error($sformatf("o_tx_busy %b %s", busy, where));
		assert (rx_valid === 1'b0) else value_error($sformatf("o_rx_valid %b %s", rx_valid, where));
		assert (rx_error === 1'b0) else value_error($sformatf("o_rx_error %b %s", rx_error, where));
	endtask

	task automatic send_request(input logic [DATA_W-1:0] d);
		next_cycle();
		valid_count = 0;
		tx_data     = d;
		tx_start    = 1'b1;
		next_cycle();
		tx_start = 1'b0;
		@(negedge tx_clk);
		assert (busy === 1'b1) else value_error("o_tx_busy did not rise after a request");
	endtask

	// follows the line from the start edge, returns at the stop bit middle
	task automatic sample_tx_frame(input logic [DATA_W-1:0] d);
		int waited;
		waited = 0;
		while (serial_out !== 1'b0) begin
			if (waited > BIT_CLKS) begin
				report_failure("timeout: o_serial did not fall to a start bit within one bit");
			end
			@(negedge tx_clk);
			waited++;
		end
		repeat (BIT_CLKS / 2) @(negedge tx_clk);
		assert (serial_out === 1'b0) else value_error("start bit is not 0");
		for (int i = 0; i < DATA_W; i++) begin
			repeat (BIT_CLKS) @(negedge tx_clk);
			assert (serial_out === d[i])
				else value_error($sformatf("data bit %0d is %b, expected %b", i, serial_out, d[i]));
		end
		repeat (BIT_CLKS) @(negedge tx_clk);
		assert (serial_out === xor_parity(d))
			else value_error($sformatf("parity bit %b for data %h", serial_out, d));
		repeat (BIT_CLKS) @(negedge tx_clk);
		assert (serial_out === 1'b1) else value_error("stop bit is not 1");
		assert (busy === 1'b1) else value_error("o_tx_busy fell before the end of the stop bit");
	endtask

	task automatic wait_tx_idle();
		int waited;
		waited = 0;
		while (busy !== 1'b0) begin
			if (waited > BIT_CLKS) begin
				report_failure("timeout: o_tx_busy stayed high past the end of the stop bit");
			end
			@(negedge tx_clk);
			waited++;
		end
	endtask

	task automatic wait_for_valid(input int max_clks);
		int waited;
		waited = 0;
		while (valid_count == 0) begin
			if (waited >= max_clks) begin
				report_failure($sformatf("timeout: no o_rx_valid pulse within %0d cycles", max_clks));
			end
			@(posedge tx_clk); // count changes on negedges only
			waited++;
		end
	endtask

	task automatic expect_received(input logic [DATA_W-1:0] d, input logic err);
		assert (valid_count == 1)
			else value_error($sformatf("%0d o_rx_valid pulses, expected 1", valid_count));
		assert (seen_data === d)
			else value_error($sformatf("o_rx_data %h, expected %h", seen_data, d));
		assert (seen_error === err)
			else value_error($sformatf("o_rx_error %b, expected %b", seen_error, err));
	endtask

	task automatic drive_line_bit(input logic b);
		line_drv = b;
		repeat (BIT_CLKS) next_cycle();
	endtask

	task automatic drive_line_frame(input logic [DATA_W-1:0] d, input logic par, input logic stop);
		next_cycle();
		valid_count = 0;
		drive_line_bit(1'b0); // start
		for (int i = 0; i < DATA_W; i++) begin
			drive_line_bit(d[i]);
		end
		drive_line_bit(par);
		drive_line_bit(stop);
		line_drv = 1'b1; // back to idle
	endtask

	task automatic reset_state();
		reset_tx = 1'b1;
		repeat (RESET_CYCLES) begin
			next_cycle();
			expect_idle_outputs("during reset");
		end
		reset_tx = 1'b0;
		repeat (20) begin
			@(negedge tx_clk);
			expect_idle_outputs("after reset");
		end
	endtask

	task automatic frame_format();
		logic [DATA_W-1:0] d;
		d        = 8'hd3; // five ones, parity bit 1
		loopback = 1'b1;
		send_request(d);
		sample_tx_frame(d);
		wait_for_valid(BIT_CLKS);
		wait_tx_idle();
		expect_received(d, 1'b0);
	endtask

	task automatic loopback_words();
		logic [DATA_W-1:0] d;
		loopback = 1'b1;
		for (int w = 0; w < LOOP_WORDS; w++) begin
			draw_data(d);
			send_request(d);
			sample_tx_frame(d);
			wait_for_valid(BIT_CLKS);
			wait_tx_idle();
			repeat (BIT_CLKS) @(negedge tx_clk); // room for a stray second pulse
			expect_received(d, 1'b0);
		end
	endtask

	task automatic request_while_busy();
		logic [DATA_W-1:0] first;
		logic [DATA_W-1:0] second;
		loopback = 1'b1;
		draw_data(first);
		second = ~first; // always differs
		send_request(first);
		fork
			sample_tx_frame(first);
			begin
				repeat (5 * BIT_CLKS) next_cycle(); // well inside the data bits
				tx_data  = second;
				tx_start = 1'b1;
				next_cycle();
				tx_start = 1'b0;
			end
		join
		wait_for_valid(BIT_CLKS);
		wait_tx_idle();
		repeat (3 * BIT_CLKS) begin
			@(negedge tx_clk);
			assert ((serial_out === 1'b1) && (busy === 1'b0))
				else value_error("a second frame started after a request during busy");
		end
		expect_received(first, 1'b0);
	endtask

	task automatic receiver_errors();
		logic [DATA_W-1:0] d;
		line_drv = 1'b1;
		loopback = 1'b0;
		draw_data(d);
		drive_line_frame(d, ~xor_parity(d), 1'b1); // parity bit inverted
		wait_for_valid(BIT_CLKS);
		repeat (2 * BIT_CLKS) next_cycle();
		expect_received(d, 1'b1);
		draw_data(d);
		drive_line_frame(d, xor_parity(d), 1'b0); // low stop bit
		wait_for_valid(BIT_CLKS);
		repeat (2 * BIT_CLKS) next_cycle();
		expect_received(d, 1'b1);
	endtask

	task automatic false_start();
		logic [DATA_W-1:0] d;
		line_drv = 1'b1;
		loopback = 1'b0;
		next_cycle();
		valid_count = 0;
		line_drv    = 1'b0; // short low glitch
		repeat (4) next_cycle();
		line_drv = 1'b1;
		repeat (2 * FRAME_BITS * BIT_CLKS) @(negedge tx_clk);
		assert (valid_count == 0) else value_error("o_rx_valid pulsed after a 4 cycle glitch");
		draw_data(d);
		drive_line_frame(d, xor_parity(d), 1'b1);
		wait_for_valid(BIT_CLKS);
		repeat (BIT_CLKS) next_cycle();
		expect_received(d, 1'b0);
	endtask

	initial begin
		tx_clk      = 1'b0;
		reset_tx    = 1'b1;
		tx_start    = 1'b0;
		tx_data     = '0;
		line_drv    = 1'b1;
		loopback    = 1'b0; // known line level during reset
		valid_count = 0;
		seen_data   = '0;
		seen_error  = 1'b0;
		lfsr_q      = 16'd38337;
		reset_state();
		frame_format();
		loopback_words();
		request_while_busy();
		receiver_errors();
		false_start();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- verilog.f
hdl/uart_pkg.sv
hdl/uart_tick_gen.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_top.sv
test/tb_uart_top.sv

//--- Bender.yml
package:
  name: uart_parity

sources:
  - hdl/uart_pkg.sv
  - hdl/uart_tick_gen.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/uart_top.sv
  - target: test
    files:
      - test/tb_uart_top.sv
